/* rtl/cachePkg.sv */
// Data cache shared types
`default_nettype none

package cachePkg;

   // Address and data widths
   localparam int addrBits = 32;
   localparam int wordBits = 64;

   // Sixteen lines only, so random traffic keeps colliding
   localparam int indexBits = 4;
   localparam int numLines = 1 << indexBits;

   // Eight 64-bit words per line, byte offset inside a word
   localparam int wordSelBits = 3;
   localparam int byteSelBits = 3;
   localparam int lineWords = 1 << wordSelBits;

   // Tag takes whatever is left of the address
   localparam int tagBits = addrBits - indexBits - wordSelBits - byteSelBits;

   // Request id echoed back to the core
   localparam int idBits = 4;

   // Address split as the cache sees it, tag on top
   typedef struct packed {
      logic [tagBits-1:0]     tag;
      logic [indexBits-1:0]   index;
      logic [wordSelBits-1:0] wordSel;
      logic [byteSelBits-1:0] byteSel;
   } cacheAddrFieldsT;

   // Same 32 bits, either as a plain byte address or as fields
   typedef union packed {
      logic [addrBits-1:0] raw;
      cacheAddrFieldsT     fields;
   } cacheAddrU;

   // Core request, one word read or write
   typedef struct packed {
      cacheAddrU           addr;
      logic [wordBits-1:0] wdata;
      logic                write;
      logic [idBits-1:0]   id;
   } coreReqT;

   // Core response, data plus the echoed id
   typedef struct packed {
      logic [wordBits-1:0] rdata;
      logic [idBits-1:0]   id;
   } coreRespT;

   // Memory request, line fill when write is low
   typedef struct packed {
      cacheAddrU           addr;
      logic [wordBits-1:0] wdata;
      logic                write;
   } memReqT;

   // One fill beat from memory
   typedef struct packed {
      logic [wordBits-1:0] data;
   } memRespT;

   // Full data SRAM row, word 0 in the low bits
   typedef logic [lineWords-1:0][wordBits-1:0] lineT;

endpackage

`default_nettype wire

/* rtl/cacheSram.sv */
// Registered-read SRAM
`timescale 1ns/1ns
`default_nettype none

module cacheSram #(
   parameter int rowBits = 512,
   parameter int depthBits = 4,
   parameter int wordEnBits = 8
) (
   input  logic                  rwArbiterCacheBus,
   input  logic [depthBits-1:0]  readAddr,
   output logic [rowBits-1:0]    readData,
   input  logic [depthBits-1:0]  writeAddr,
   input  logic [rowBits-1:0]    writeData,
   input  logic [wordEnBits-1:0] writeEn
);

   // Width of the slice behind one enable bit
   localparam int sliceBits = rowBits / wordEnBits;
   localparam int depth = 1 << depthBits;

   // Storage array, no reset on contents
   logic [rowBits-1:0] mem [depth];

   // Read data shows up one cycle after the address
   // Read of the row being written returns the old contents
   always_ff @(posedge rwArbiterCacheBus) begin
      readData <= mem[readAddr];
   end

   // Each enable bit owns its own slice of the row
   always_ff @(posedge rwArbiterCacheBus) begin
      for (int i = 0; i < wordEnBits; i++) begin
         if (writeEn[i]) begin
            mem[writeAddr][i*sliceBits +: sliceBits] <= writeData[i*sliceBits +: sliceBits];
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/dmDataCache.sv */
// Direct-mapped write-through data cache
`timescale 1ns/1ns
`default_nettype none

module dmDataCache (
   input  logic               rwArbiterCacheBus,
   input  logic               arstN,
   // Core side
   input  logic               coreReqCyc,
   input  cachePkg::coreReqT  coreReq,
   output logic               coreReqAck,
   output logic               coreRespCyc,
   output cachePkg::coreRespT coreResp,
   input  logic               coreRespAck,
   // Memory side
   output logic               memReqCyc,
   output cachePkg::memReqT   memReq,
   input  logic               memReqAck,
   input  logic               memRespCyc,
   input  cachePkg::memRespT  memResp,
   output logic               memRespAck
);

   import cachePkg::*;

   // Controller states
   typedef enum logic [2:0] {
      stateIdle,
      stateLookup,
      stateCompare,
      stateFill,
      stateMerge,
      stateWriteThrough,
      stateRespond
   } cacheStateT;

   cacheStateT state;

   // Accepted request, held until the response completes
   coreReqT reqQ;

   // One valid bit per line
   logic [numLines-1:0] validQ;

   // Set in compare when the line had to be filled
   logic missQ;

   // Beat counter and collected fill data
   logic [wordSelBits-1:0] beatCnt;
   lineT fillBuf;

   // SRAM side signals
   lineT                  lineRead;
   lineT                  mergeLine;
   logic [tagBits-1:0]    tagRead;
   logic [lineWords-1:0]  dataWe;
   logic                  tagWe;
   logic [indexBits-1:0]  lineIdx;
   logic [wordSelBits-1:0] wordIdx;

   // Decoded events of this cycle
   logic      accept;
   logic      hit;
   logic      startFill;
   logic      hitRespond;
   logic      beatTake;
   logic      lastBeat;
   logic      startWrite;
   cacheAddrU fillAddr;

   // Both SRAMs are indexed by the latched request
   assign lineIdx = reqQ.addr.fields.index;
   assign wordIdx = reqQ.addr.fields.wordSel;

   // Line data, eight words per row
   cacheSram #(
      .rowBits    (lineWords * wordBits),
      .depthBits  (indexBits),
      .wordEnBits (lineWords)
   ) dataSram (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .readAddr          (lineIdx),
      .readData          (lineRead),
      .writeAddr         (lineIdx),
      .writeData         (mergeLine),
      .writeEn           (dataWe)
   );

   // Tags, one enable for the whole row
   cacheSram #(
      .rowBits    (tagBits),
      .depthBits  (indexBits),
      .wordEnBits (1)
   ) tagSram (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .readAddr          (lineIdx),
      .readData          (tagRead),
      .writeAddr         (lineIdx),
      .writeData         (reqQ.addr.fields.tag),
      .writeEn           (tagWe)
   );

   // Core request taken only while idle
   assign accept = (state == stateIdle) && coreReqCyc;

   // Tag SRAM output is valid in the compare cycle
   assign hit = validQ[lineIdx] && (tagRead == reqQ.addr.fields.tag);

   assign startFill  = (state == stateCompare) && !hit;
   assign hitRespond = (state == stateCompare) && hit && !reqQ.write;

   // A beat is taken once, the ack pulse masks the repeat
   assign beatTake = (state == stateFill) && memRespCyc && !memRespAck;
   assign lastBeat = beatTake && (beatCnt == wordSelBits'(lineWords - 1));

   // Write-through leaves merge once the SRAM is updated
   assign startWrite = (state == stateMerge) && reqQ.write;

   // Line fill address, word and byte offset cleared
   always_comb begin
      fillAddr.fields.tag     = reqQ.addr.fields.tag;
      fillAddr.fields.index   = reqQ.addr.fields.index;
      fillAddr.fields.wordSel = '0;
      fillAddr.fields.byteSel = '0;
   end

   // Row to write: fill data with the store word laid on top
   // On a write hit only the one word enable is set, so the rest is ignored
   always_comb begin
      mergeLine = fillBuf;
      if (reqQ.write) begin
         mergeLine[wordIdx] = reqQ.wdata;
      end
   end

   // Whole row after a fill, single word on a write hit
   always_comb begin
      dataWe = '0;
      if (state == stateMerge) begin
         if (missQ) begin
            dataWe = '1;
         end else begin
            dataWe = lineWords'(1) << wordIdx;
         end
      end
   end

   // Tag only changes when the line was refilled
   assign tagWe = (state == stateMerge) && missQ;

   // Control state and handshake bits
   always_ff @(posedge rwArbiterCacheBus or negedge arstN) begin
      if (!arstN) begin
         state       <= stateIdle;
         coreReqAck  <= 1'b0;
         coreRespCyc <= 1'b0;
         memReqCyc   <= 1'b0;
         memRespAck  <= 1'b0;
         missQ       <= 1'b0;
         beatCnt     <= '0;
         validQ      <= '0;
      end else begin
         // Acks are single-cycle pulses
         coreReqAck <= 1'b0;
         memRespAck <= 1'b0;

         // Memory request drops after the ack edge
         if (memReqCyc && memReqAck) begin
            memReqCyc <= 1'b0;
         end

         case (state)
            stateIdle: begin
               if (accept) begin
                  coreReqAck <= 1'b1;
                  state      <= stateLookup;
               end
            end

            // SRAM read in flight
            stateLookup: begin
               state <= stateCompare;
            end

            stateCompare: begin
               missQ <= !hit;
               if (startFill) begin
                  // One line fill, beats come back in word order
                  memReqCyc <= 1'b1;
                  beatCnt   <= '0;
                  state     <= stateFill;
               end else if (hitRespond) begin
                  coreRespCyc <= 1'b1;
                  state       <= stateRespond;
               end else begin
                  // Write hit goes straight to the merge
                  state <= stateMerge;
               end
            end

            stateFill: begin
               if (beatTake) begin
                  memRespAck <= 1'b1;
                  beatCnt    <= beatCnt + 1'b1;
                  if (lastBeat) begin
                     state <= stateMerge;
                  end
               end
            end

            stateMerge: begin
               // Line now holds this tag
               if (missQ) begin
                  validQ[lineIdx] <= 1'b1;
               end
               if (startWrite) begin
                  memReqCyc <= 1'b1;
                  state     <= stateWriteThrough;
               end else begin
                  coreRespCyc <= 1'b1;
                  state       <= stateRespond;
               end
            end

            // Word write complete at its ack, no beats follow
            stateWriteThrough: begin
               if (memReqAck) begin
                  coreRespCyc <= 1'b1;
                  state       <= stateRespond;
               end
            end

            // Hold the response until the core takes it
            stateRespond: begin
               if (coreRespAck) begin
                  coreRespCyc <= 1'b0;
                  state       <= stateIdle;
               end
            end

            default: begin
               state <= stateIdle;
            end
         endcase
      end
   end

   // Payload registers, loaded on the events above
   always_ff @(posedge rwArbiterCacheBus) begin
      if (accept) begin
         reqQ <= coreReq;
      end

      if (beatTake) begin
         fillBuf[beatCnt] <= memResp.data;
      end

      // Memory request stays put until acked
      if (startFill) begin
         memReq.addr  <= fillAddr;
         memReq.wdata <= reqQ.wdata;
         memReq.write <= 1'b0;
      end else if (startWrite) begin
         memReq.addr.raw <= reqQ.addr.raw;
         memReq.wdata    <= reqQ.wdata;
         memReq.write    <= 1'b1;
      end

      // Read hit answers from the SRAM row
      if (hitRespond) begin
         coreResp.rdata <= lineRead[wordIdx];
         coreResp.id    <= reqQ.id;
      end

      // After a fill or merge, answer with the word as stored
      if (state == stateMerge) begin
         coreResp.rdata <= mergeLine[wordIdx];
         coreResp.id    <= reqQ.id;
      end
   end

endmodule

`default_nettype wire

/* rtl/dataCacheTop.sv */
// Data cache subsystem top
`timescale 1ns/1ns
`default_nettype none

module dataCacheTop (
   input  logic               rwArbiterCacheBus,
   input  logic               arstN,
   // Core port
   input  logic               coreReqCyc,
   input  cachePkg::coreReqT  coreReq,
   output logic               coreReqAck,
   output logic               coreRespCyc,
   output cachePkg::coreRespT coreResp,
   input  logic               coreRespAck,
   // Memory port, an arbiter would attach here later
   output logic               memReqCyc,
   output cachePkg::memReqT   memReq,
   input  logic               memReqAck,
   input  logic               memRespCyc,
   input  cachePkg::memRespT  memResp,
   output logic               memRespAck
);

   // Single direct-mapped data cache
   dmDataCache cacheCore (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .arstN             (arstN),
      // Core handshake
      .coreReqCyc        (coreReqCyc),
      .coreReq           (coreReq),
      .coreReqAck        (coreReqAck),
      .coreRespCyc       (coreRespCyc),
      .coreResp          (coreResp),
      .coreRespAck       (coreRespAck),
      // Memory handshake
      .memReqCyc         (memReqCyc),
      .memReq            (memReq),
      .memReqAck         (memReqAck),
      .memRespCyc        (memRespCyc),
      .memResp           (memResp),
      .memRespAck        (memRespAck)
   );

endmodule

`default_nettype wire

/* bench/memoryModel.sv */
// Behavioral backing memory
`timescale 1ns/1ns
`default_nettype none

module memoryModel #(
   parameter int maxStall = 4
) (
   input  logic              rwArbiterCacheBus,
   input  logic              memReqCyc,
   input  cachePkg::memReqT  memReq,
   output logic              memReqAck,
   output logic              memRespCyc,
   output cachePkg::memRespT memResp,
   input  logic              memRespAck,
   // Record of each accepted request, one cycle wide
   output logic              seenValid,
   output cachePkg::memReqT  seenReq
);

   import cachePkg::*;

   // Written words only, the rest comes from the fill pattern
   logic [wordBits-1:0] store [logic [addrBits-byteSelBits-1:0]];
   memReqT req;

   // Start contents, every address bit takes part
   function automatic logic [wordBits-1:0] initialWord(input logic [28:0] wordAddr);
      return {3'b101, wordAddr, 3'b010, wordAddr ^ 29'h0B6D3A5F};
   endfunction

   task automatic waitCycle();
      @(posedge rwArbiterCacheBus);
      #5;
   endtask

   initial begin
      memReqAck = 1'b0;
      memRespCyc = 1'b0;
      memResp = '0;
      seenValid = 1'b0;
      seenReq = '0;
      forever begin
         waitCycle();
         if (memReqCyc) begin
            req = memReq;
            repeat ($urandom_range(0, maxStall)) waitCycle();
            // Ack pulse and report go out together
            memReqAck = 1'b1;
            seenValid = 1'b1;
            seenReq = req;
            if (req.write) begin
               store[req.addr.raw[addrBits-1:byteSelBits]] = req.wdata;
            end
            waitCycle();
            memReqAck = 1'b0;
            seenValid = 1'b0;
            // Line fill, eight beats in word order
            for (int beat = 0; beat < lineWords && !req.write; beat++) begin
               logic [28:0] wordAddr;
               wordAddr = req.addr.raw[addrBits-1:byteSelBits] + 29'(beat);
               repeat ($urandom_range(0, maxStall)) waitCycle();
               memRespCyc = 1'b1;
               memResp.data = store.exists(wordAddr) ? store[wordAddr] : initialWord(wordAddr);
               waitCycle();
               while (!memRespAck) waitCycle();
               memRespCyc = 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* bench/cacheBus_sva.sv */
// Cache bus handshake assertions
`timescale 1ns/1ns
`default_nettype none

module cacheBus_sva (
   input logic               rwArbiterCacheBus,
   input logic               arstN,
   input logic               coreReqAck,
   input logic               coreRespCyc,
   input cachePkg::coreRespT coreResp,
   input logic               coreRespAck,
   input logic               memReqCyc,
   input cachePkg::memReqT   memReq,
   input logic               memReqAck
);

   // Response held until the core takes it
   respHeld: assert property (@(posedge rwArbiterCacheBus) disable iff (!arstN)
      coreRespCyc && !coreRespAck |=> coreRespCyc && $stable(coreResp))
      else $error("coreResp changed or dropped before coreRespAck");

   // Memory request held until memory takes it
   memReqHeld: assert property (@(posedge rwArbiterCacheBus) disable iff (!arstN)
      memReqCyc && !memReqAck |=> memReqCyc && $stable(memReq))
      else $error("memReq changed or dropped before memReqAck");

   // Fills are line aligned
   fillAligned: assert property (@(posedge rwArbiterCacheBus) disable iff (!arstN)
      memReqCyc && !memReq.write |-> memReq.addr.raw[5:0] == 6'd0)
      else $error("line fill address not line aligned");

   // Request ack is a single pulse
   reqAckPulse: assert property (@(posedge rwArbiterCacheBus) disable iff (!arstN)
      coreReqAck |=> !coreReqAck)
      else $error("coreReqAck held longer than one cycle");

endmodule

`default_nettype wire

/* bench/cacheTb.sv */
// Data cache testbench
`timescale 1ns/1ns
`default_nettype none

module cacheTb;

   import cachePkg::*;

   localparam int clkPeriod = 100;
   localparam int numRequests = 300;
   localparam int maxStall = 4;
   localparam int maxRespDelay = 3;
   // Write miss with every stall at its longest
   localparam int worstCycles = 6 + 2 * (maxStall + 2) + lineWords * (maxStall + 3) + maxRespDelay;
   localparam int timeoutNs = numRequests * worstCycles * clkPeriod * 2;

   logic      rwArbiterCacheBus;
   logic      arstN;
   logic      coreReqCyc;
   coreReqT   coreReq;
   logic      coreReqAck;
   logic      coreRespCyc;
   coreRespT  coreResp;
   logic      coreRespAck;
   logic      memReqCyc;
   memReqT    memReq;
   logic      memReqAck;
   logic      memRespCyc;
   memRespT   memResp;
   logic      memRespAck;
   logic      seenValid;
   memReqT    seenReq;

   // Memory requests seen during the current core request
   memReqT memLog [$];

   // Reference model, tag table and memory copy
   logic [tagBits-1:0]  refTag [numLines];
   logic                refValid [numLines];
   logic [wordBits-1:0] refMem [logic [28:0]];
   logic [tagBits-1:0]  tagPool [4];
   int unsigned         seedValue;
   coreReqT             req;

   dataCacheTop dataCacheTop_inst (.*);

   memoryModel #(.maxStall(maxStall)) memModel (.*);

   bind dmDataCache cacheBus_sva busChecks (.*);

   initial begin
      rwArbiterCacheBus = 1'b0;
      forever #(clkPeriod / 2) rwArbiterCacheBus = ~rwArbiterCacheBus;
   end

   // Report is stable for the whole cycle around this edge
   always @(posedge rwArbiterCacheBus) begin
      if (seenValid) memLog.push_back(seenReq);
   end

   initial begin
      #(timeoutNs);
      $display("Run hung, no progress within %0d ns", timeoutNs);
      abortRun();
   end

   // Start contents of memory, same pattern as the memory model
   function automatic logic [wordBits-1:0] refRead(input logic [28:0] wordAddr);
      if (refMem.exists(wordAddr)) return refMem[wordAddr];
      return {3'b101, wordAddr, 3'b010, wordAddr ^ 29'h0B6D3A5F};
   endfunction

   task automatic nextCycle();
      @(posedge rwArbiterCacheBus);
      #5;
   endtask

   task automatic abortRun();
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         abortRun();
      end
   endtask

   task automatic checkCoreResp(input coreRespT got, input coreRespT exp);
      if (got !== exp) begin
         $display("ERROR coreResp rdata %h id %h expected rdata %h id %h",
                  got.rdata, got.id, exp.rdata, exp.id);
         abortRun();
      end
   endtask

   // Fill data field is unused, so only writes compare it
   task automatic checkMemReq(input memReqT got, input memReqT exp);
      if (got.addr.raw !== exp.addr.raw || got.write !== exp.write ||
          (exp.write && got.wdata !== exp.wdata)) begin
         $display("ERROR memReq addr %h write %h wdata %h expected addr %h write %h wdata %h",
                  got.addr.raw, got.write, got.wdata, exp.addr.raw, exp.write, exp.wdata);
         abortRun();
      end
   endtask

   task automatic runRequest(input coreReqT cmd);
      memReqT              expReq [$];
      memReqT              expOne;
      coreRespT            exp;
      logic                hit;
      int                  waitCnt;
      logic [indexBits-1:0] idx;
      logic [28:0]         wordAddr;
      idx = cmd.addr.fields.index;
      wordAddr = cmd.addr.raw[addrBits-1:byteSelBits];
      hit = refValid[idx] && refTag[idx] == cmd.addr.fields.tag;
      // Miss fills the whole line first
      if (!hit) begin
         expOne = '0;
         expOne.addr.fields.tag = cmd.addr.fields.tag;
         expOne.addr.fields.index = idx;
         expReq.push_back(expOne);
         refValid[idx] = 1'b1;
         refTag[idx] = cmd.addr.fields.tag;
      end
      // Store goes through as one word write
      if (cmd.write) begin
         expOne.addr = cmd.addr;
         expOne.wdata = cmd.wdata;
         expOne.write = 1'b1;
         expReq.push_back(expOne);
         refMem[wordAddr] = cmd.wdata;
      end
      exp.rdata = refRead(wordAddr);
      exp.id = cmd.id;
      memLog.delete();
      coreReq = cmd;
      coreReqCyc = 1'b1;
      nextCycle();
      // Cache is idle here, so the ack follows the first edge
      checkBit("coreReqAck", coreReqAck, 1'b1);
      coreReqCyc = 1'b0;
      waitCnt = 0;
      while (!coreRespCyc) begin
         nextCycle();
         waitCnt++;
      end
      checkCoreResp(coreResp, exp);
      if (hit && !cmd.write && waitCnt != 2) begin
         $display("Read hit answered after %0d cycles instead of 2", waitCnt);
         abortRun();
      end
      // Random back-pressure before taking the response
      repeat ($urandom_range(0, maxRespDelay)) nextCycle();
      coreRespAck = 1'b1;
      nextCycle();
      coreRespAck = 1'b0;
      checkBit("coreRespCyc", coreRespCyc, 1'b0);
      if (memLog.size() != expReq.size()) begin
         $display("ERROR memReq count %h expected %h", memLog.size(), expReq.size());
         abortRun();
      end
      foreach (expReq[i]) checkMemReq(memLog[i], expReq[i]);
   endtask

   initial begin
      seedValue = $urandom(20644);
      arstN = 1'b0;
      coreReqCyc = 1'b0;
      coreReq = '0;
      coreRespAck = 1'b0;
      // Few tags so indexes keep colliding
      tagPool[0] = 22'h000001;
      tagPool[1] = 22'h2A5C3;
      tagPool[2] = 22'h15F0E;
      tagPool[3] = 22'h3FFFFF;
      foreach (refValid[i]) refValid[i] = 1'b0;
      repeat (3) @(posedge rwArbiterCacheBus);
      #5;
      arstN = 1'b1;
      checkBit("coreReqAck", coreReqAck, 1'b0);
      checkBit("coreRespCyc", coreRespCyc, 1'b0);
      checkBit("memReqCyc", memReqCyc, 1'b0);
      checkBit("memRespAck", memRespAck, 1'b0);
      for (int n = 0; n < numRequests; n++) begin
         req.addr.fields.tag = tagPool[$urandom_range(0, 3)];
         req.addr.fields.index = indexBits'($urandom_range(0, numLines - 1));
         req.addr.fields.wordSel = wordSelBits'($urandom_range(0, lineWords - 1));
         req.addr.fields.byteSel = '0;
         req.wdata = {$urandom, $urandom};
         req.write = ($urandom_range(0, 9) < 4);
         req.id = idBits'(n);
         runRequest(req);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
rtl/cachePkg.sv
rtl/cacheSram.sv
rtl/dmDataCache.sv
rtl/dataCacheTop.sv
bench/memoryModel.sv
bench/cacheBus_sva.sv
bench/cacheTb.sv
